// File: build.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verif/tb_dcache_mem.sv
verif/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f \
    --top-module tb_dcache \
    -Mdir obj_dir -o vtb_dcache

./obj_dir/vtb_dcache | tee "$LOG"

# the result is decided by the log alone
if grep -qx "STATUS: PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: verif/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module tb_dcache;

    import dcache_pkg::*;

    localparam int TIMEOUT = 100;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      core_req_valid;
    logic      core_req_ready;
    core_req_t core_req;
    logic      core_rsp_valid;
    core_rsp_t core_rsp;
    logic      mem_req_valid;
    logic      mem_req_ready;
    mem_req_t  mem_req;
    logic      mem_rsp_valid;
    line_t     mem_rsp_data;

    // reference memory image, stored words only
    logic [63:0]          image [logic [31:0]];
    // cache contents as the rules predict them
    logic [`DC_TAG_W-1:0] model_tag [`DC_SETS][`DC_WAYS];
    logic                 model_valid [`DC_SETS][`DC_WAYS];
    logic                 model_victim [`DC_SETS];

    // accepted memory requests, in order
    mem_req_t mem_log [$];
    mem_req_t held_req;
    logic     held = 1'b0;

    int value_errors = 0;
    int proto_errors = 0;
    int timeouts = 0;
    int lat;

    always #2 clk = ~clk;

    dcache_top i_dut (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .core_req_valid_i (core_req_valid),
        .core_req_ready_o (core_req_ready),
        .core_req_i       (core_req),
        .core_rsp_valid_o (core_rsp_valid),
        .core_rsp_o       (core_rsp),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_ready_i  (mem_req_ready),
        .mem_req_o        (mem_req),
        .mem_rsp_valid_i  (mem_rsp_valid),
        .mem_rsp_data_i   (mem_rsp_data)
    );

    tb_dcache_mem i_mem (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_ready_o (mem_req_ready),
        .mem_req_i       (mem_req),
        .mem_rsp_valid_o (mem_rsp_valid),
        .mem_rsp_data_o  (mem_rsp_data)
    );

    // --------------------------------------------------------------------------
    // memory bus monitor, request log and back-pressure stability
    // --------------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (held) begin
                assert (mem_req_valid && mem_req == held_req) else begin
                    proto_errors++;
                    $display("[FAIL] %0t mem_req_o under back-pressure exp %h/1 got %h/%b",
                             $time, held_req, mem_req, mem_req_valid);
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                mem_log.push_back(mem_req);
            end
            held     = mem_req_valid && !mem_req_ready;
            held_req = mem_req;
        end
    end

    function automatic logic [63:0] image_word(input logic [31:0] addr);
        logic [31:0] waddr;
        waddr = {addr[31:3], 3'b000};
        if (image.exists(waddr)) begin
            return image[waddr];
        end else begin
            return {waddr ^ 32'ha5c3_5a3c, waddr * 32'h0001_0193 + 32'h7f4a_7c15};
        end
    endfunction

    function automatic logic [31:0] make_addr(input logic [23:0] tag, input logic [3:0] set,
                                              input logic word);
        return {tag, set, word, 3'b000};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("[FAIL] %0t %s exp %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic finish_run();
        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, proto_errors, timeouts);
        if (value_errors == 0 && proto_errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    // --------------------------------------------------------------------------
    // one core request, checked against the image and the cache model
    // --------------------------------------------------------------------------
    task automatic run_req(input logic [31:0] addr, input logic we, input logic [7:0] be,
                           input logic [63:0] wdata);
        int          n;
        int          hit_w;
        int          log_start;
        logic [3:0]  set;
        logic        cacheable;
        logic        mem_seen;
        logic [63:0] rdata;
        logic [63:0] exp;
        logic [31:0] exp_addr;
        mem_op_e     exp_op;
        mem_req_t    req;
        // nothing more is sent once a wait has run out
        if (timeouts != 0) begin
            return;
        end
        set       = addr[7:4];
        cacheable = !addr[`DC_UNCACHED_BIT];
        hit_w     = -1;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (cacheable && model_valid[set][w] && model_tag[set][w] == addr[31:8]) begin
                hit_w = w;
            end
        end
        log_start = mem_log.size();
        @(negedge clk);
        core_req_valid = 1'b1;
        core_req       = '{addr, we, be, wdata};
        n = 0;
        @(posedge clk);
        while (!core_req_ready) begin
            n++;
            if (n > TIMEOUT) begin
                report_timeout("core_req_ready_o");
                return;
            end
            @(posedge clk);
        end
        @(negedge clk);
        core_req_valid = 1'b0;
        // count edges from acceptance to the response
        lat = 1;
        @(posedge clk);
        while (!core_rsp_valid) begin
            lat++;
            if (lat > TIMEOUT) begin
                report_timeout("core_rsp_valid_o");
                return;
            end
            @(posedge clk);
        end
        rdata    = core_rsp.rdata;
        mem_seen = mem_rsp_valid;
        check_value("core_rsp_o.rdata", rdata, we ? 64'h0 : image_word(addr));
        if (!we && hit_w >= 0) begin
            check_value("load hit latency", 64'(lat), 64'd1);
            check_value("memory requests on hit", 64'(mem_log.size() - log_start), 64'd0);
        end else begin
            check_value("memory requests", 64'(mem_log.size() - log_start), 64'd1);
            assert (mem_seen) else begin
                proto_errors++;
                $display("core response at %0t came without a memory response", $time);
            end
            if (we) begin
                exp_op = MEM_WRITE_WORD;
            end else if (cacheable) begin
                exp_op = MEM_READ_LINE;
            end else begin
                exp_op = MEM_READ_WORD;
            end
            exp_addr = (exp_op == MEM_READ_LINE) ? {addr[31:4], 4'h0} : {addr[31:3], 3'h0};
            if (mem_log.size() > log_start) begin
                req = mem_log[log_start];
                check_value("mem_req_o.op", 64'(req.op), 64'(exp_op));
                check_value("mem_req_o.addr", 64'(req.addr), 64'(exp_addr));
                if (we) begin
                    check_value("mem_req_o.be", 64'(req.be), 64'(be));
                    check_value("mem_req_o.wdata", req.wdata, wdata);
                end
            end
        end
        // image and model follow the request
        if (we) begin
            exp = image_word(addr);
            for (int b = 0; b < `DC_BE_W; b++) begin
                if (be[b]) begin
                    exp[b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            image[{addr[31:3], 3'b000}] = exp;
        end else if (cacheable && hit_w < 0) begin
            model_tag[set][model_victim[set]]   = addr[31:8];
            model_valid[set][model_victim[set]] = 1'b1;
            model_victim[set]                   = !model_victim[set];
        end
    endtask

    initial begin
        logic [31:0] addr;
        void'($urandom(68860));
        rst_n          = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        for (int s = 0; s < `DC_SETS; s++) begin
            model_victim[s] = 1'b0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        check_value("core_req_ready_o", 64'(core_req_ready), 64'd1);
        check_value("core_rsp_valid_o", 64'(core_rsp_valid), 64'd0);
        check_value("mem_req_valid_o", 64'(mem_req_valid), 64'd0);

        // round robin in set 3 with tags A, B, C
        run_req(make_addr(24'h11, 4'd3, 1'b0), 1'b0, 8'h00, 64'h0);
        run_req(make_addr(24'h22, 4'd3, 1'b1), 1'b0, 8'h00, 64'h0);
        run_req(make_addr(24'h33, 4'd3, 1'b0), 1'b0, 8'h00, 64'h0);
        run_req(make_addr(24'h22, 4'd3, 1'b0), 1'b0, 8'h00, 64'h0);
        check_value("latency of B after C", 64'(lat), 64'd1);
        run_req(make_addr(24'h11, 4'd3, 1'b0), 1'b0, 8'h00, 64'h0);
        assert (lat != 1) else begin
            value_errors++;
            $display("[FAIL] %0t latency of A after C exp miss got %0d", $time, lat);
        end

        // partial stores to a cached line and to an uncached line
        run_req(make_addr(24'h11, 4'd3, 1'b0), 1'b1, 8'h0f, 64'h1122_3344_5566_7788);
        run_req(make_addr(24'h11, 4'd3, 1'b0), 1'b0, 8'h00, 64'h0);
        run_req(make_addr(24'h44, 4'd5, 1'b1), 1'b1, 8'hc3, 64'hdead_beef_cafe_f00d);
        run_req(make_addr(24'h44, 4'd5, 1'b1), 1'b0, 8'h00, 64'h0);

        // uncacheable loads repeat as word reads
        run_req(32'h8000_1238, 1'b0, 8'h00, 64'h0);
        run_req(32'h8000_1238, 1'b0, 8'h00, 64'h0);

        // random mix over a few tags of four sets
        for (int i = 0; i < 120; i++) begin
            addr = make_addr({($urandom_range(5, 0) == 0), 21'h0, 2'($urandom_range(2, 0))},
                             4'($urandom_range(3, 0)), 1'($urandom));
            run_req(addr, ($urandom_range(3, 0) == 0), 8'($urandom), {$urandom, $urandom});
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: verif/tb_dcache_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module tb_dcache_mem (
    input  wire                        clk_i,
    input  wire                        rst_ni,
    input  wire                        mem_req_valid_i,
    output logic                       mem_req_ready_o,
    input  wire dcache_pkg::mem_req_t  mem_req_i,
    output logic                       mem_rsp_valid_o,
    output dcache_pkg::line_t          mem_rsp_data_o
);

    import dcache_pkg::*;

    // words written so far, keyed by word address
    logic [`DC_WORD_W-1:0] written [logic [`DC_ADDR_W-1:0]];

    // handshake seen at the last rising edge
    logic     accept_q;
    mem_req_t req_q;
    // request being served
    mem_req_t cur;
    logic     busy;
    int       delay;

    // untouched memory reads as a hash of the word address
    function automatic logic [63:0] addr_hash(input logic [31:0] addr);
        return {addr ^ 32'ha5c3_5a3c, addr * 32'h0001_0193 + 32'h7f4a_7c15};
    endfunction

    function automatic logic [63:0] read_word(input logic [31:0] addr);
        logic [31:0] waddr;
        waddr = {addr[31:3], 3'b000};
        if (written.exists(waddr)) begin
            return written[waddr];
        end else begin
            return addr_hash(waddr);
        end
    endfunction

    // byte-enabled word write
    task automatic write_word(input mem_req_t req);
        logic [63:0] word;
        word = read_word(req.addr);
        for (int b = 0; b < `DC_BE_W; b++) begin
            if (req.be[b]) begin
                word[b*8 +: 8] = req.wdata[b*8 +: 8];
            end
        end
        written[{req.addr[31:3], 3'b000}] = word;
    endtask

    initial begin
        mem_req_ready_o = 1'b0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_data_o  = '0;
        busy            = 1'b0;
        delay           = 0;
    end

    always @(posedge clk_i) begin
        accept_q <= rst_ni && mem_req_valid_i && mem_req_ready_o;
        req_q    <= mem_req_i;
    end

    // --------------------------------------------------------------------------
    // outputs change on the falling edge only
    // --------------------------------------------------------------------------
    always @(negedge clk_i) begin
        mem_rsp_valid_o <= 1'b0;
        if (!rst_ni) begin
            mem_req_ready_o <= 1'b0;
            busy = 1'b0;
        end else if (accept_q) begin
            // a write lands in the image right at acceptance
            cur = req_q;
            if (cur.op == MEM_WRITE_WORD) begin
                write_word(cur);
            end
            busy  = 1'b1;
            delay = $urandom_range(3, 0);
            mem_req_ready_o <= 1'b0;
        end else if (busy) begin
            if (delay == 0) begin
                busy = 1'b0;
                mem_rsp_valid_o <= 1'b1;
                case (cur.op)
                    MEM_READ_LINE:  mem_rsp_data_o <= {read_word(cur.addr + 32'd8),
                                                       read_word(cur.addr)};
                    MEM_READ_WORD:  mem_rsp_data_o <= {64'h0, read_word(cur.addr)};
                    default:        mem_rsp_data_o <= '0;
                endcase
            end else begin
                delay--;
            end
        end else begin
            // ready three times out of four while idle
            mem_req_ready_o <= ($urandom_range(3, 0) != 0);
        end
    end

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module dcache_top (
    input  wire                         clk_i,
    input  wire                         rst_ni,
    // core side
    input  wire                         core_req_valid_i,
    output logic                        core_req_ready_o,
    input  wire dcache_pkg::core_req_t  core_req_i,
    output logic                        core_rsp_valid_o,
    output dcache_pkg::core_rsp_t       core_rsp_o,
    // memory side
    output logic                        mem_req_valid_o,
    input  wire                         mem_req_ready_i,
    output dcache_pkg::mem_req_t        mem_req_o,
    input  wire                         mem_rsp_valid_i,
    input  wire dcache_pkg::line_t      mem_rsp_data_i
);

    import dcache_pkg::*;

    // --------------------------------------------------------------------------
    // controller to store wiring
    // --------------------------------------------------------------------------
    logic [`DC_INDEX_W-1:0]    index;
    logic [`DC_TAG_W-1:0]      tag;
    way_vec_t                  hit_way;
    way_vec_t                  victim_way;
    line_t [`DC_WAYS-1:0]      way_lines;
    logic                      fill;
    line_t                     fill_line;
    logic                      store;
    logic [`DC_WORD_SEL_W-1:0] word_sel;
    logic [`DC_WORD_W-1:0]     wdata;
    logic [`DC_BE_W-1:0]       be;

    dcache_ctrl i_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .core_req_valid_i (core_req_valid_i),
        .core_req_ready_o (core_req_ready_o),
        .core_req_i       (core_req_i),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_o       (core_rsp_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_o        (mem_req_o),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_data_i   (mem_rsp_data_i),
        .index_o          (index),
        .tag_o            (tag),
        .hit_way_i        (hit_way),
        .way_lines_i      (way_lines),
        .fill_o           (fill),
        .fill_line_o      (fill_line),
        .store_o          (store),
        .word_sel_o       (word_sel),
        .wdata_o          (wdata),
        .be_o             (be)
    );

    // tags and data are looked up side by side with the same index
    dcache_tag_store i_tag_store (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .index_i      (index),
        .tag_i        (tag),
        .fill_i       (fill),
        .hit_way_o    (hit_way),
        .victim_way_o (victim_way)
    );

    // refill lands in the victim way, stores in the hit way
    dcache_data_store i_data_store (
        .clk_i       (clk_i),
        .index_i     (index),
        .fill_i      (fill),
        .fill_way_i  (victim_way),
        .fill_line_i (fill_line),
        .store_i     (store),
        .store_way_i (hit_way),
        .word_sel_i  (word_sel),
        .wdata_i     (wdata),
        .be_i        (be),
        .way_lines_o (way_lines)
    );

endmodule

`default_nettype wire

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module dcache_ctrl (
    input  wire                                   clk_i,
    input  wire                                   rst_ni,
    // core request channel
    input  wire                                   core_req_valid_i,
    output logic                                  core_req_ready_o,
    input  wire dcache_pkg::core_req_t            core_req_i,
    // core response, one pulse per request
    output logic                                  core_rsp_valid_o,
    output dcache_pkg::core_rsp_t                 core_rsp_o,
    // memory request channel
    output logic                                  mem_req_valid_o,
    input  wire                                   mem_req_ready_i,
    output dcache_pkg::mem_req_t                  mem_req_o,
    // memory response
    input  wire                                   mem_rsp_valid_i,
    input  wire dcache_pkg::line_t                mem_rsp_data_i,
    // lookup into both stores
    output logic [`DC_INDEX_W-1:0]                index_o,
    output logic [`DC_TAG_W-1:0]                  tag_o,
    input  wire dcache_pkg::way_vec_t             hit_way_i,
    input  wire dcache_pkg::line_t [`DC_WAYS-1:0] way_lines_i,
    // store updates
    output logic                                  fill_o,
    output dcache_pkg::line_t                     fill_line_o,
    output logic                                  store_o,
    output logic [`DC_WORD_SEL_W-1:0]             word_sel_o,
    output logic [`DC_WORD_W-1:0]                 wdata_o,
    output logic [`DC_BE_W-1:0]                   be_o
);

    import dcache_pkg::*;

    // byte offset bits inside one word
    localparam int unsigned BYTE_OFF_W = `DC_OFFSET_W - `DC_WORD_SEL_W;

    ctrl_state_e           state_q, state_d;
    // captured request, held until the response
    core_req_t             req_q;
    // memory operation picked in LOOKUP
    mem_op_e               op_q, op_d;

    logic                  cacheable;
    logic                  lookup_hit;
    line_t                 hit_line;
    logic [`DC_WORD_W-1:0] hit_word;
    logic [`DC_WORD_W-1:0] refill_word;

    // --------------------------------------------------------------------------
    // address split and store side outputs
    // --------------------------------------------------------------------------
    assign index_o    = req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign tag_o      = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign word_sel_o = req_q.addr[`DC_OFFSET_W-1:BYTE_OFF_W];
    assign wdata_o    = req_q.wdata;
    assign be_o       = req_q.be;
    // refill data goes straight from memory into the victim way
    assign fill_line_o = mem_rsp_data_i;

    assign cacheable  = !req_q.addr[`DC_UNCACHED_BIT];
    assign lookup_hit = cacheable && (|hit_way_i);

    // hit-way data select, hit vector is one-hot
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (hit_way_i[w]) begin
                hit_line = hit_line | way_lines_i[w];
            end
        end
    end

    assign hit_word    = hit_line[word_sel_o*`DC_WORD_W +: `DC_WORD_W];
    assign refill_word = mem_rsp_data_i[word_sel_o*`DC_WORD_W +: `DC_WORD_W];

    // --------------------------------------------------------------------------
    // memory request
    // --------------------------------------------------------------------------
    assign mem_req_valid_o = (state_q == MEM_REQ);

    // payload is built from registers only so it holds under back-pressure
    always_comb begin
        mem_req_o.op    = op_q;
        mem_req_o.be    = req_q.be;
        mem_req_o.wdata = req_q.wdata;
        if (op_q == MEM_READ_LINE) begin
            mem_req_o.addr = {req_q.addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
        end else begin
            mem_req_o.addr = {req_q.addr[`DC_ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
        end
    end

    // --------------------------------------------------------------------------
    // control FSM
    // --------------------------------------------------------------------------
    assign core_req_ready_o = (state_q == IDLE);

    always_comb begin
        state_d          = state_q;
        op_d             = op_q;
        core_rsp_valid_o = 1'b0;
        core_rsp_o       = '0;
        store_o          = 1'b0;
        fill_o           = 1'b0;
        case (state_q)
            IDLE: begin
                if (core_req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!req_q.we && lookup_hit) begin
                    // load hit answers right here
                    core_rsp_valid_o = 1'b1;
                    core_rsp_o.rdata = hit_word;
                    state_d          = IDLE;
                end else begin
                    state_d = MEM_REQ;
                    if (req_q.we) begin
                        // write-through, a hit line is updated now
                        op_d    = MEM_WRITE_WORD;
                        store_o = lookup_hit;
                    end else if (cacheable) begin
                        op_d = MEM_READ_LINE;
                    end else begin
                        op_d = MEM_READ_WORD;
                    end
                end
            end
            MEM_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                if (mem_rsp_valid_i) begin
                    core_rsp_valid_o = 1'b1;
                    state_d          = IDLE;
                    case (op_q)
                        MEM_READ_LINE: begin
                            // allocate and return the requested word
                            core_rsp_o.rdata = refill_word;
                            fill_o           = 1'b1;
                        end
                        MEM_READ_WORD: core_rsp_o.rdata = mem_rsp_data_i[`DC_WORD_W-1:0];
                        default:       core_rsp_o.rdata = '0;
                    endcase
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request capture at acceptance
    always_ff @(posedge clk_i) begin
        if (core_req_valid_i && core_req_ready_o) begin
            req_q <= core_req_i;
        end
        op_q <= op_d;
    end

endmodule

`default_nettype wire

// File: verilog/dcache_data_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module dcache_data_store (
    input  wire                                   clk_i,
    input  wire [`DC_INDEX_W-1:0]                 index_i,
    // line refill
    input  wire                                   fill_i,
    input  wire dcache_pkg::way_vec_t             fill_way_i,
    input  wire dcache_pkg::line_t                fill_line_i,
    // word store into a hit line
    input  wire                                   store_i,
    input  wire dcache_pkg::way_vec_t             store_way_i,
    input  wire [`DC_WORD_SEL_W-1:0]              word_sel_i,
    input  wire [`DC_WORD_W-1:0]                  wdata_i,
    input  wire [`DC_BE_W-1:0]                    be_i,
    // all ways of the indexed set
    output dcache_pkg::line_t [`DC_WAYS-1:0]      way_lines_o
);

    import dcache_pkg::*;

    // line storage, flop based
    line_t lines_q [`DC_SETS][`DC_WAYS];

    // combinational read of every way in the set
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_lines_o[w] = lines_q[index_i][w];
        end
    end

    // --------------------------------------------------------------------------
    // write port
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (fill_i && fill_way_i[w]) begin
                // whole line from memory
                lines_q[index_i][w] <= fill_line_i;
            end else if (store_i && store_way_i[w]) begin
                // only enabled bytes of the selected word change
                for (int b = 0; b < `DC_BE_W; b++) begin
                    if (be_i[b]) begin
                        lines_q[index_i][w][word_sel_i*`DC_WORD_W + b*8 +: 8] <=
                            wdata_i[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/dcache_tag_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module dcache_tag_store (
    input  wire                         clk_i,
    input  wire                         rst_ni,
    // lookup and fill use the same captured index and tag
    input  wire [`DC_INDEX_W-1:0]       index_i,
    input  wire [`DC_TAG_W-1:0]         tag_i,
    input  wire                         fill_i,
    output dcache_pkg::way_vec_t        hit_way_o,
    output dcache_pkg::way_vec_t        victim_way_o
);

    import dcache_pkg::*;

    // tag array, flop based
    logic [`DC_TAG_W-1:0] tags_q [`DC_SETS][`DC_WAYS];
    // valid bits per set
    way_vec_t             valid_q [`DC_SETS];
    // round-robin pointer per set, selects the next way to replace
    logic [`DC_SETS-1:0]  victim_q;

    // --------------------------------------------------------------------------
    // parallel hit compare
    // --------------------------------------------------------------------------
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            // a way hits only when valid and the tags agree
            hit_way_o[w] = valid_q[index_i][w] && (tags_q[index_i][w] == tag_i);
        end
    end

    // pointer bit turned into a one-hot way vector
    assign victim_way_o = way_vec_t'(1) << victim_q[index_i];

    // --------------------------------------------------------------------------
    // valid and victim state
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_q[s] <= '0;
            end
            victim_q <= '0;
        end else if (fill_i) begin
            // refilled way becomes valid
            valid_q[index_i]  <= valid_q[index_i] | victim_way_o;
            // other way is next in line
            victim_q[index_i] <= ~victim_q[index_i];
        end
    end

    // tag write into the victim way on refill
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (fill_i && victim_way_o[w]) begin
                tags_q[index_i][w] <= tag_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/dcache_pkg.sv
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

    // one bit per way, used one-hot for hit and victim
    typedef logic [`DC_WAYS-1:0] way_vec_t;

    // a full cache line
    typedef logic [`DC_LINE_W-1:0] line_t;

    // --------------------------------------------------------------------------
    // core side
    // --------------------------------------------------------------------------
    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        // high for a store
        logic                  we;
        logic [`DC_BE_W-1:0]   be;
        logic [`DC_WORD_W-1:0] wdata;
    } core_req_t;

    // zero for stores
    typedef struct packed {
        logic [`DC_WORD_W-1:0] rdata;
    } core_rsp_t;

    // --------------------------------------------------------------------------
    // memory side
    // --------------------------------------------------------------------------
    typedef enum logic [1:0] {
        MEM_READ_LINE,
        MEM_READ_WORD,
        MEM_WRITE_WORD
    } mem_op_e;

    // line-aligned addr for line reads, word-aligned otherwise
    typedef struct packed {
        mem_op_e               op;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_BE_W-1:0]   be;
        logic [`DC_WORD_W-1:0] wdata;
    } mem_req_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MEM_REQ,
        MEM_WAIT
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: verilog/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// --------------------------------------------------------------------------
// address and data widths
// --------------------------------------------------------------------------
// byte address width
`define DC_ADDR_W 32
// core word and its byte enables
`define DC_WORD_W 64
`define DC_BE_W 8
// one line holds two words
`define DC_LINE_W 128

// --------------------------------------------------------------------------
// geometry
// --------------------------------------------------------------------------
`define DC_WAYS 2
`define DC_SETS 16
`define DC_INDEX_W 4
// byte offset within a line, word select is its upper part
`define DC_OFFSET_W 4
`define DC_WORD_SEL_W 1
// address bits above index and offset
`define DC_TAG_W 24

// addresses with this bit set bypass the cache
`define DC_UNCACHED_BIT 31

`endif
